//--- logic/cmd_pkg.sv
package cmd_pkg;

  // Command codes from decode
  // Codes outside this list execute as NOP
  typedef enum logic [5:0] {
    CMD_NOP   = 6'd0,
    CMD_ADD   = 6'd1,
    CMD_ADC   = 6'd2,
    CMD_INC   = 6'd3,
    CMD_SUB   = 6'd4,
    CMD_SBB   = 6'd5,
    CMD_DEC   = 6'd6,
    CMD_CMP   = 6'd7,
    CMD_AND   = 6'd8,
    CMD_TEST  = 6'd9,
    CMD_OR    = 6'd10,
    CMD_XOR   = 6'd11,
    CMD_NOT   = 6'd12,
    CMD_SHL   = 6'd13,
    CMD_SHR   = 6'd14,
    CMD_ROL   = 6'd15,
    CMD_ROR   = 6'd16,
    CMD_PUSH  = 6'd17,
    CMD_POP   = 6'd18,
    CMD_CALL  = 6'd19,
    CMD_RET   = 6'd20,
    CMD_LOOP  = 6'd21,
    CMD_MOV   = 6'd22,
    CMD_XCHG  = 6'd23,
    CMD_CDQ   = 6'd24,
    CMD_STC   = 6'd25,
    CMD_CLC   = 6'd26,
    CMD_STD   = 6'd27,
    CMD_CLD   = 6'd28,
    CMD_LAHF  = 6'd29,
    CMD_SAHF  = 6'd30,
    CMD_JMP   = 6'd31,
    CMD_JZ    = 6'd32,
    CMD_JNZ   = 6'd33,
    CMD_JECXZ = 6'd34
  } cmd_t;

  // ALU core operations, nine of them so four bits
  typedef enum logic [3:0] {
    ALU_OP_ADD = 4'd0,
    ALU_OP_SUB = 4'd1,
    ALU_OP_AND = 4'd2,
    ALU_OP_OR  = 4'd3,
    ALU_OP_XOR = 4'd4,
    ALU_OP_SHL = 4'd5,
    ALU_OP_SHR = 4'd6,
    ALU_OP_ROL = 4'd7,
    ALU_OP_ROR = 4'd8
  } alu_op_t;

  // ALU control word as decoded by execute
  typedef struct packed {
    alu_op_t op;
    // ADC and SBB fold CF into the sum
    logic    use_carry;
    // INC and DEC use a constant one as second operand
    logic    src_one;
    // NOT as XOR with all ones
    logic    invert_result;
    // NOT and the stack or ECX adjusts
    logic    no_flags;
    // INC and DEC leave CF alone
    logic    keep_cf;
    // Logic ops clear CF and OF
    logic    clear_cf_of;
  } alu_cntl_t;

endpackage

//--- logic/arch_pkg.sv
package arch_pkg;

  // EFLAGS bit positions
  localparam int EFLAGS_CF = 0;
  localparam int EFLAGS_PF = 2;
  localparam int EFLAGS_AF = 4;
  localparam int EFLAGS_ZF = 6;
  localparam int EFLAGS_SF = 7;
  localparam int EFLAGS_DF = 10;
  localparam int EFLAGS_OF = 11;

  // Flags the execution units read and write
  typedef struct packed {
    logic of;
    logic df;
    logic sf;
    logic zf;
    logic af;
    logic pf;
    logic cf;
  } status_t;

  // One decoded instruction entering the stage
  typedef struct packed {
    cmd_pkg::cmd_t opc;
    logic [31:0]   eflags;
    logic          ecx_is_zero;
    logic [31:0]   eip;
    logic [3:0]    instr_len;
    logic [31:0]   opnd0_r;
    logic [31:0]   opnd1_r;
    logic [31:0]   opnd2_r;
  } exec_req_t;

  // Architectural effect of that instruction
  typedef struct packed {
    logic [31:0] eflags;
    logic [31:0] next_eip;
    logic [31:0] opnd0_w;
    logic [31:0] opnd1_w;
  } exec_rsp_t;

endpackage

//--- logic/alu.sv
`timescale 1ns/1ns

module alu (
  input  cmd_pkg::alu_cntl_t cntl,
  input  arch_pkg::status_t  status_in,
  input  logic [31:0]        opnd0,
  input  logic [31:0]        opnd1,
  output logic [31:0]        result,
  output arch_pkg::status_t  status_out
);

  logic        is_sub;
  logic [31:0] src;
  logic [31:0] src_x;
  logic        cin;
  logic [32:0] sum;
  logic        arith_cf;
  logic        arith_of;
  logic        arith_af;
  logic [4:0]  cnt;
  logic [32:0] shl_full;
  logic [32:0] shr_full;
  logic [63:0] rol_full;
  logic [63:0] ror_full;
  logic        res_zf;
  logic        res_sf;
  logic        res_pf;

  assign is_sub = (cntl.op == cmd_pkg::ALU_OP_SUB);

  // Second operand, constant one for INC/DEC, all ones for NOT
  always_comb begin
    if (cntl.src_one) begin
      src = 32'd1;
    end else if (cntl.invert_result) begin
      src = '1;
    end else begin
      src = opnd1;
    end
  end

  // Subtract as a + ~b + 1, borrow-in turns the +1 off
  assign src_x    = is_sub ? ~src : src;
  assign cin      = (cntl.use_carry & status_in.cf) ^ is_sub;
  assign sum      = {1'b0, opnd0} + {1'b0, src_x} + {32'd0, cin};
  // Borrow is the inverted carry on subtract
  assign arith_cf = sum[32] ^ is_sub;
  assign arith_of = (opnd0[31] == src_x[31]) && (sum[31] != opnd0[31]);
  // Carry out of bit 3 shows up as a flip of bit 4
  assign arith_af = opnd0[4] ^ src[4] ^ sum[4];

  // Shift count is five bits as on 32-bit x86
  assign cnt = opnd1[4:0];
  // Extra bit catches the last bit shifted out
  assign shl_full = {1'b0, opnd0} << cnt;
  assign shr_full = {opnd0, 1'b0} >> cnt;
  // Doubled word so rotates are plain shifts
  assign rol_full = {opnd0, opnd0} << cnt;
  assign ror_full = {opnd0, opnd0} >> cnt;

  always_comb begin
    case (cntl.op)
      cmd_pkg::ALU_OP_ADD,
      cmd_pkg::ALU_OP_SUB: result = sum[31:0];
      cmd_pkg::ALU_OP_AND: result = opnd0 & src;
      cmd_pkg::ALU_OP_OR:  result = opnd0 | src;
      cmd_pkg::ALU_OP_XOR: result = opnd0 ^ src;
      cmd_pkg::ALU_OP_SHL: result = shl_full[31:0];
      cmd_pkg::ALU_OP_SHR: result = shr_full[32:1];
      cmd_pkg::ALU_OP_ROL: result = rol_full[63:32];
      cmd_pkg::ALU_OP_ROR: result = ror_full[31:0];
      default:             result = opnd0;
    endcase
  end

  assign res_zf = (result == 32'd0);
  assign res_sf = result[31];
  // PF is even parity of the low byte
  assign res_pf = ~^result[7:0];

  always_comb begin
    status_out = status_in;
    if (!cntl.no_flags) begin
      case (cntl.op)
        cmd_pkg::ALU_OP_ADD,
        cmd_pkg::ALU_OP_SUB: begin
          status_out.of = arith_of;
          status_out.af = arith_af;
          status_out.zf = res_zf;
          status_out.sf = res_sf;
          status_out.pf = res_pf;
          if (!cntl.keep_cf) begin
            status_out.cf = arith_cf;
          end
        end
        cmd_pkg::ALU_OP_AND,
        cmd_pkg::ALU_OP_OR,
        cmd_pkg::ALU_OP_XOR: begin
          status_out.zf = res_zf;
          status_out.sf = res_sf;
          status_out.pf = res_pf;
          if (cntl.clear_cf_of) begin
            status_out.cf = 1'b0;
            status_out.of = 1'b0;
          end
        end
        cmd_pkg::ALU_OP_SHL,
        cmd_pkg::ALU_OP_SHR: begin
          // Zero count leaves every flag
          if (cnt != 5'd0) begin
            status_out.cf = (cntl.op == cmd_pkg::ALU_OP_SHL) ? shl_full[32] : shr_full[0];
            status_out.zf = res_zf;
            status_out.sf = res_sf;
            status_out.pf = res_pf;
          end
        end
        cmd_pkg::ALU_OP_ROL: begin
          if (cnt != 5'd0) begin
            status_out.cf = result[0];
          end
        end
        cmd_pkg::ALU_OP_ROR: begin
          if (cnt != 5'd0) begin
            status_out.cf = result[31];
          end
        end
        default: status_out = status_in;
      endcase
    end
  end

endmodule

//--- logic/move_unit.sv
`timescale 1ns/1ns

module move_unit (
  input  logic        swap,
  input  logic        sext,
  input  logic [31:0] opnd0_r,
  input  logic [31:0] opnd1_r,
  output logic [31:0] opnd0_w,
  output logic [31:0] opnd1_w
);

  // MOV and XCHG both land opnd1 in opnd0
  // CDQ fills EDX with the sign of EAX
  always_comb begin
    if (sext) begin
      opnd0_w = {32{opnd1_r[31]}};
    end else begin
      opnd0_w = opnd1_r;
    end
  end

  // Only XCHG writes back the other way
  always_comb begin
    if (swap) begin
      opnd1_w = opnd0_r;
    end else begin
      opnd1_w = opnd1_r;
    end
  end

endmodule

//--- logic/meta_unit.sv
`timescale 1ns/1ns

module meta_unit (
  input  cmd_pkg::cmd_t     opc,
  input  logic [31:0]       opnd_in,
  input  arch_pkg::status_t status_in,
  output logic              ah_wr,
  output logic [31:0]       result,
  output arch_pkg::status_t status_out
);

  logic [7:0] ah_in;
  logic [7:0] flags_lo;

  // AH is bits 15:8 of EAX
  assign ah_in = opnd_in[15:8];

  // Low EFLAGS byte, reserved bits at their architectural values
  assign flags_lo = {status_in.sf, status_in.zf, 1'b0, status_in.af,
                     1'b0, status_in.pf, 1'b1, status_in.cf};

  // LAHF is the only command here with a register result
  assign ah_wr  = (opc == cmd_pkg::CMD_LAHF);
  assign result = {opnd_in[31:16], flags_lo, opnd_in[7:0]};

  always_comb begin
    status_out = status_in;
    case (opc)
      cmd_pkg::CMD_STC: status_out.cf = 1'b1;
      cmd_pkg::CMD_CLC: status_out.cf = 1'b0;
      cmd_pkg::CMD_STD: status_out.df = 1'b1;
      cmd_pkg::CMD_CLD: status_out.df = 1'b0;
      cmd_pkg::CMD_SAHF: begin
        // AH holds flags at their EFLAGS positions
        status_out.sf = ah_in[arch_pkg::EFLAGS_SF];
        status_out.zf = ah_in[arch_pkg::EFLAGS_ZF];
        status_out.af = ah_in[arch_pkg::EFLAGS_AF];
        status_out.pf = ah_in[arch_pkg::EFLAGS_PF];
        status_out.cf = ah_in[arch_pkg::EFLAGS_CF];
      end
      default: status_out = status_in;
    endcase
  end

endmodule

//--- logic/cfu.sv
`timescale 1ns/1ns

module cfu (
  input  cmd_pkg::cmd_t opc,
  input  logic [31:0]   eflags,
  input  logic          ecx_is_zero,
  input  logic [31:0]   eip,
  input  logic [3:0]    instr_len,
  input  logic [31:0]   address,
  output logic [31:0]   next_eip
);

  logic        take;
  logic [31:0] fall_through;

  // Sequential flow steps over the current instruction
  assign fall_through = eip + {28'd0, instr_len};

  // Branch condition per command
  always_comb begin
    case (opc)
      cmd_pkg::CMD_JMP,
      cmd_pkg::CMD_CALL,
      cmd_pkg::CMD_RET:   take = 1'b1;
      cmd_pkg::CMD_JZ:    take = eflags[arch_pkg::EFLAGS_ZF];
      cmd_pkg::CMD_JNZ:   take = ~eflags[arch_pkg::EFLAGS_ZF];
      cmd_pkg::CMD_JECXZ: take = ecx_is_zero;
      // Zero test here is on the decremented ECX
      cmd_pkg::CMD_LOOP:  take = ~ecx_is_zero;
      default:            take = 1'b0;
    endcase
  end

  // Target comes in on opnd0
  assign next_eip = take ? address : fall_through;

endmodule

//--- logic/execute.sv
`timescale 1ns/1ns

module execute (
  input  arch_pkg::exec_req_t req,
  output arch_pkg::exec_rsp_t rsp
);

  cmd_pkg::alu_cntl_t alu_cntl;
  arch_pkg::status_t  status_in;
  arch_pkg::status_t  alu_status_out;
  arch_pkg::status_t  meta_status_out;
  logic               is_alu;
  logic               is_adjust;
  logic               no_wr;
  logic               is_mu;
  logic               mu_swap;
  logic               mu_sext;
  logic               is_meta;
  logic               ah_wr;
  logic [31:0]        alu_opnd0;
  logic [31:0]        alu_opnd1;
  logic [31:0]        alu_result;
  logic [31:0]        mu_opnd0_w;
  logic [31:0]        mu_opnd1_w;
  logic [31:0]        meta_result;
  logic [31:0]        ret_addr;
  logic [31:0]        opnd0_w;
  logic               cfu_ecx_is_zero;

  // Status flags back into EFLAGS with IF, TF and reserved bits from base
  function automatic logic [31:0] merge_status(input logic [31:0] base,
                                               input arch_pkg::status_t st);
    logic [31:0] merged;
    merged = base;
    merged[arch_pkg::EFLAGS_OF] = st.of;
    merged[arch_pkg::EFLAGS_DF] = st.df;
    merged[arch_pkg::EFLAGS_SF] = st.sf;
    merged[arch_pkg::EFLAGS_ZF] = st.zf;
    merged[arch_pkg::EFLAGS_AF] = st.af;
    merged[arch_pkg::EFLAGS_PF] = st.pf;
    merged[arch_pkg::EFLAGS_CF] = st.cf;
    return merged;
  endfunction

  // Command decode into unit controls
  always_comb begin
    alu_cntl    = '0;
    is_alu      = 1'b0;
    is_adjust   = 1'b0;
    no_wr       = 1'b0;
    is_mu       = 1'b0;
    mu_swap     = 1'b0;
    mu_sext     = 1'b0;
    is_meta     = 1'b0;
    case (req.opc)
      cmd_pkg::CMD_ADD, cmd_pkg::CMD_ADC, cmd_pkg::CMD_INC: begin
        is_alu             = 1'b1;
        alu_cntl.op        = cmd_pkg::ALU_OP_ADD;
        alu_cntl.use_carry = (req.opc == cmd_pkg::CMD_ADC);
        alu_cntl.src_one   = (req.opc == cmd_pkg::CMD_INC);
        alu_cntl.keep_cf   = (req.opc == cmd_pkg::CMD_INC);
      end
      cmd_pkg::CMD_SUB, cmd_pkg::CMD_SBB, cmd_pkg::CMD_DEC, cmd_pkg::CMD_CMP: begin
        is_alu             = 1'b1;
        alu_cntl.op        = cmd_pkg::ALU_OP_SUB;
        alu_cntl.use_carry = (req.opc == cmd_pkg::CMD_SBB);
        alu_cntl.src_one   = (req.opc == cmd_pkg::CMD_DEC);
        alu_cntl.keep_cf   = (req.opc == cmd_pkg::CMD_DEC);
        no_wr              = (req.opc == cmd_pkg::CMD_CMP);
      end
      cmd_pkg::CMD_AND, cmd_pkg::CMD_TEST: begin
        is_alu               = 1'b1;
        alu_cntl.op          = cmd_pkg::ALU_OP_AND;
        alu_cntl.clear_cf_of = 1'b1;
        no_wr                = (req.opc == cmd_pkg::CMD_TEST);
      end
      cmd_pkg::CMD_OR, cmd_pkg::CMD_XOR: begin
        is_alu               = 1'b1;
        alu_cntl.op          = (req.opc == cmd_pkg::CMD_OR) ? cmd_pkg::ALU_OP_OR
                                                            : cmd_pkg::ALU_OP_XOR;
        alu_cntl.clear_cf_of = 1'b1;
      end
      cmd_pkg::CMD_NOT: begin
        is_alu                 = 1'b1;
        alu_cntl.op            = cmd_pkg::ALU_OP_XOR;
        alu_cntl.invert_result = 1'b1;
        alu_cntl.no_flags      = 1'b1;
      end
      cmd_pkg::CMD_SHL: begin
        is_alu      = 1'b1;
        alu_cntl.op = cmd_pkg::ALU_OP_SHL;
      end
      cmd_pkg::CMD_SHR: begin
        is_alu      = 1'b1;
        alu_cntl.op = cmd_pkg::ALU_OP_SHR;
      end
      cmd_pkg::CMD_ROL: begin
        is_alu      = 1'b1;
        alu_cntl.op = cmd_pkg::ALU_OP_ROL;
      end
      cmd_pkg::CMD_ROR: begin
        is_alu      = 1'b1;
        alu_cntl.op = cmd_pkg::ALU_OP_ROR;
      end
      // Stack and ECX adjusts leave the flags untouched
      cmd_pkg::CMD_PUSH, cmd_pkg::CMD_CALL, cmd_pkg::CMD_LOOP: begin
        is_alu            = 1'b1;
        is_adjust         = 1'b1;
        alu_cntl.op       = cmd_pkg::ALU_OP_SUB;
        alu_cntl.no_flags = 1'b1;
      end
      cmd_pkg::CMD_POP, cmd_pkg::CMD_RET: begin
        is_alu            = 1'b1;
        is_adjust         = 1'b1;
        alu_cntl.op       = cmd_pkg::ALU_OP_ADD;
        alu_cntl.no_flags = 1'b1;
      end
      cmd_pkg::CMD_MOV, cmd_pkg::CMD_XCHG, cmd_pkg::CMD_CDQ: begin
        is_mu   = 1'b1;
        mu_swap = (req.opc == cmd_pkg::CMD_XCHG);
        mu_sext = (req.opc == cmd_pkg::CMD_CDQ);
      end
      cmd_pkg::CMD_STC, cmd_pkg::CMD_CLC, cmd_pkg::CMD_STD, cmd_pkg::CMD_CLD,
      cmd_pkg::CMD_LAHF, cmd_pkg::CMD_SAHF: is_meta = 1'b1;
      default: is_alu = 1'b0;
    endcase
  end

  assign status_in.of = req.eflags[arch_pkg::EFLAGS_OF];
  assign status_in.df = req.eflags[arch_pkg::EFLAGS_DF];
  assign status_in.sf = req.eflags[arch_pkg::EFLAGS_SF];
  assign status_in.zf = req.eflags[arch_pkg::EFLAGS_ZF];
  assign status_in.af = req.eflags[arch_pkg::EFLAGS_AF];
  assign status_in.pf = req.eflags[arch_pkg::EFLAGS_PF];
  assign status_in.cf = req.eflags[arch_pkg::EFLAGS_CF];

  // Adjusts work on ESP or ECX in opnd1 with the amount in opnd2
  assign alu_opnd0 = is_adjust ? req.opnd1_r : req.opnd0_r;
  assign alu_opnd1 = is_adjust ? req.opnd2_r : req.opnd1_r;

  alu alu_x (
    .cntl       (alu_cntl),
    .status_in  (status_in),
    .opnd0      (alu_opnd0),
    .opnd1      (alu_opnd1),
    .result     (alu_result),
    .status_out (alu_status_out)
  );

  move_unit move_x (
    .swap    (mu_swap),
    .sext    (mu_sext),
    .opnd0_r (req.opnd0_r),
    .opnd1_r (req.opnd1_r),
    .opnd0_w (mu_opnd0_w),
    .opnd1_w (mu_opnd1_w)
  );

  meta_unit meta_x (
    .opc        (req.opc),
    .opnd_in    (req.opnd0_r),
    .status_in  (status_in),
    .ah_wr      (ah_wr),
    .result     (meta_result),
    .status_out (meta_status_out)
  );

  // LOOP tests ECX after its decrement
  assign cfu_ecx_is_zero = (req.opc == cmd_pkg::CMD_LOOP) ? (alu_result == 32'd0)
                                                          : req.ecx_is_zero;

  cfu cfu_x (
    .opc         (req.opc),
    .eflags      (req.eflags),
    .ecx_is_zero (cfu_ecx_is_zero),
    .eip         (req.eip),
    .instr_len   (req.instr_len),
    .address     (req.opnd0_r),
    .next_eip    (rsp.next_eip)
  );

  // Return address pushed by CALL
  assign ret_addr = req.eip + {28'd0, req.instr_len};

  always_comb begin
    if (req.opc == cmd_pkg::CMD_CALL) begin
      opnd0_w = ret_addr;
    end else if (is_adjust) begin
      // POP value was fetched into opnd0 by decode
      opnd0_w = req.opnd0_r;
    end else if (is_alu && !no_wr) begin
      opnd0_w = alu_result;
    end else if (is_mu) begin
      opnd0_w = mu_opnd0_w;
    end else if (ah_wr) begin
      opnd0_w = meta_result;
    end else begin
      opnd0_w = req.opnd0_r;
    end
  end

  assign rsp.opnd0_w = opnd0_w;

  // Adjusted ESP or ECX goes back through opnd1
  assign rsp.opnd1_w = is_mu     ? mu_opnd1_w :
                       is_adjust ? alu_result :
                                   req.opnd1_r;

  // Only the ALU and meta unit touch flags
  assign rsp.eflags = is_alu  ? merge_status(req.eflags, alu_status_out)  :
                      is_meta ? merge_status(req.eflags, meta_status_out) :
                                req.eflags;

endmodule

//--- logic/exec_stage.sv
`timescale 1ns/1ns

module exec_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  arch_pkg::exec_req_t req,
  output logic                out_valid,
  output arch_pkg::exec_rsp_t rsp
);

  arch_pkg::exec_rsp_t rsp_next;

  // Whole execute path settles within the cycle
  execute execute_x (
    .req (req),
    .rsp (rsp_next)
  );

  // One result per strobe, no back-pressure
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      rsp       <= '0;
    end else begin
      out_valid <= in_valid;
      // Result held until the next strobe
      if (in_valid) begin
        rsp <= rsp_next;
      end
    end
  end

endmodule

//--- testbench/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Even parity over the low byte, counted bit by bit
function automatic logic low_byte_parity(input logic [31:0] v);
  int ones;
  int i;
  ones = 0;
  for (i = 0; i < 8; i++) begin
    ones = ones + v[i];
  end
  return (ones % 2) == 0;
endfunction

// ZF, SF and PF taken from a result
function automatic logic [31:0] with_result_flags(input logic [31:0] fl,
                                                  input logic [31:0] res);
  logic [31:0] f;
  f = fl;
  f[arch_pkg::EFLAGS_ZF] = (res == 32'd0);
  f[arch_pkg::EFLAGS_SF] = res[31];
  f[arch_pkg::EFLAGS_PF] = low_byte_parity(res);
  return f;
endfunction

// Add or subtract in wide arithmetic, flags as the return value
function automatic logic [31:0] add_sub(input logic [31:0] fl, input logic [31:0] a,
                                        input logic [31:0] b, input logic sub,
                                        input logic cin, input logic keep_cf,
                                        output logic [31:0] res);
  logic [32:0] wide;
  logic [4:0]  nib;
  longint      sr;
  longint      ci;
  logic [31:0] f;
  ci = cin;
  if (sub) begin
    wide = {1'b0, a} - {1'b0, b} - {32'd0, cin};
    nib  = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
    sr   = longint'($signed(a)) - longint'($signed(b)) - ci;
  end else begin
    wide = {1'b0, a} + {1'b0, b} + {32'd0, cin};
    nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
    sr   = longint'($signed(a)) + longint'($signed(b)) + ci;
  end
  res = wide[31:0];
  f = with_result_flags(fl, res);
  // Top bit of the wide result is carry, or borrow when subtracting
  if (!keep_cf) begin
    f[arch_pkg::EFLAGS_CF] = wide[32];
  end
  f[arch_pkg::EFLAGS_AF] = nib[4];
  // Signed overflow when the exact value leaves the 32-bit range
  f[arch_pkg::EFLAGS_OF] = (sr > 64'sd2147483647) || (sr < -64'sd2147483648);
  return f;
endfunction

// Expected stage response for one request
function automatic arch_pkg::exec_rsp_t expected_response(input arch_pkg::exec_req_t r);
  arch_pkg::exec_rsp_t o;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic [31:0] f;
  logic [4:0]  n;
  logic [7:0]  lo;
  a = r.opnd0_r;
  b = r.opnd1_r;
  n = b[4:0];
  f = r.eflags;
  res = a;
  // Nothing written means everything passes through
  o.eflags   = r.eflags;
  o.next_eip = r.eip + {28'd0, r.instr_len};
  o.opnd0_w  = r.opnd0_r;
  o.opnd1_w  = r.opnd1_r;
  case (r.opc)
    cmd_pkg::CMD_ADD:  o.eflags = add_sub(f, a, b, 1'b0, 1'b0, 1'b0, o.opnd0_w);
    cmd_pkg::CMD_ADC:  o.eflags = add_sub(f, a, b, 1'b0, f[arch_pkg::EFLAGS_CF], 1'b0, o.opnd0_w);
    cmd_pkg::CMD_INC:  o.eflags = add_sub(f, a, 32'd1, 1'b0, 1'b0, 1'b1, o.opnd0_w);
    cmd_pkg::CMD_SUB:  o.eflags = add_sub(f, a, b, 1'b1, 1'b0, 1'b0, o.opnd0_w);
    cmd_pkg::CMD_SBB:  o.eflags = add_sub(f, a, b, 1'b1, f[arch_pkg::EFLAGS_CF], 1'b0, o.opnd0_w);
    cmd_pkg::CMD_DEC:  o.eflags = add_sub(f, a, 32'd1, 1'b1, 1'b0, 1'b1, o.opnd0_w);
    // Compare only sets flags
    cmd_pkg::CMD_CMP:  o.eflags = add_sub(f, a, b, 1'b1, 1'b0, 1'b0, res);
    cmd_pkg::CMD_AND, cmd_pkg::CMD_TEST, cmd_pkg::CMD_OR, cmd_pkg::CMD_XOR: begin
      res = (r.opc == cmd_pkg::CMD_OR)  ? (a | b) :
            (r.opc == cmd_pkg::CMD_XOR) ? (a ^ b) : (a & b);
      o.eflags = with_result_flags(f, res);
      o.eflags[arch_pkg::EFLAGS_CF] = 1'b0;
      o.eflags[arch_pkg::EFLAGS_OF] = 1'b0;
      if (r.opc != cmd_pkg::CMD_TEST) begin
        o.opnd0_w = res;
      end
    end
    cmd_pkg::CMD_NOT:  o.opnd0_w = ~a;
    // Zero count keeps result and flags as they were
    cmd_pkg::CMD_SHL: begin
      if (n != 5'd0) begin
        o.opnd0_w = a << n;
        o.eflags = with_result_flags(f, o.opnd0_w);
        o.eflags[arch_pkg::EFLAGS_CF] = a[32 - n];
      end
    end
    cmd_pkg::CMD_SHR: begin
      if (n != 5'd0) begin
        o.opnd0_w = a >> n;
        o.eflags = with_result_flags(f, o.opnd0_w);
        o.eflags[arch_pkg::EFLAGS_CF] = a[n - 1];
      end
    end
    cmd_pkg::CMD_ROL: begin
      if (n != 5'd0) begin
        o.opnd0_w = (a << n) | (a >> (32 - n));
        o.eflags[arch_pkg::EFLAGS_CF] = o.opnd0_w[0];
      end
    end
    cmd_pkg::CMD_ROR: begin
      if (n != 5'd0) begin
        o.opnd0_w = (a >> n) | (a << (32 - n));
        o.eflags[arch_pkg::EFLAGS_CF] = o.opnd0_w[31];
      end
    end
    // Stack pointer or ECX lives in opnd1, amount in opnd2
    cmd_pkg::CMD_PUSH: o.opnd1_w = r.opnd1_r - r.opnd2_r;
    cmd_pkg::CMD_POP:  o.opnd1_w = r.opnd1_r + r.opnd2_r;
    cmd_pkg::CMD_CALL: begin
      o.opnd1_w  = r.opnd1_r - r.opnd2_r;
      o.opnd0_w  = r.eip + {28'd0, r.instr_len};
      o.next_eip = r.opnd0_r;
    end
    cmd_pkg::CMD_RET: begin
      o.opnd1_w  = r.opnd1_r + r.opnd2_r;
      o.next_eip = r.opnd0_r;
    end
    cmd_pkg::CMD_LOOP: begin
      o.opnd1_w = r.opnd1_r - r.opnd2_r;
      if (o.opnd1_w != 32'd0) begin
        o.next_eip = r.opnd0_r;
      end
    end
    cmd_pkg::CMD_MOV:  o.opnd0_w = b;
    cmd_pkg::CMD_XCHG: begin
      o.opnd0_w = b;
      o.opnd1_w = a;
    end
    cmd_pkg::CMD_CDQ:  o.opnd0_w = b[31] ? 32'hffff_ffff : 32'd0;
    cmd_pkg::CMD_STC:  o.eflags[arch_pkg::EFLAGS_CF] = 1'b1;
    cmd_pkg::CMD_CLC:  o.eflags[arch_pkg::EFLAGS_CF] = 1'b0;
    cmd_pkg::CMD_STD:  o.eflags[arch_pkg::EFLAGS_DF] = 1'b1;
    cmd_pkg::CMD_CLD:  o.eflags[arch_pkg::EFLAGS_DF] = 1'b0;
    cmd_pkg::CMD_LAHF: begin
      // Reserved flag bits read back as 1, 0, 0
      lo = f[7:0];
      lo[1] = 1'b1;
      lo[3] = 1'b0;
      lo[5] = 1'b0;
      o.opnd0_w[15:8] = lo;
    end
    cmd_pkg::CMD_SAHF: begin
      o.eflags[arch_pkg::EFLAGS_SF] = a[8 + arch_pkg::EFLAGS_SF];
      o.eflags[arch_pkg::EFLAGS_ZF] = a[8 + arch_pkg::EFLAGS_ZF];
      o.eflags[arch_pkg::EFLAGS_AF] = a[8 + arch_pkg::EFLAGS_AF];
      o.eflags[arch_pkg::EFLAGS_PF] = a[8 + arch_pkg::EFLAGS_PF];
      o.eflags[arch_pkg::EFLAGS_CF] = a[8 + arch_pkg::EFLAGS_CF];
    end
    cmd_pkg::CMD_JMP:  o.next_eip = a;
    cmd_pkg::CMD_JZ:   o.next_eip = f[arch_pkg::EFLAGS_ZF] ? a : o.next_eip;
    cmd_pkg::CMD_JNZ:  o.next_eip = f[arch_pkg::EFLAGS_ZF] ? o.next_eip : a;
    cmd_pkg::CMD_JECXZ: o.next_eip = r.ecx_is_zero ? a : o.next_eip;
    default: o.next_eip = r.eip + {28'd0, r.instr_len};
  endcase
  return o;
endfunction

`endif

//--- testbench/tb_exec_stage.sv
`timescale 1ns/1ns

module tb_exec_stage;

  localparam int NUM_REQ = 600;
  localparam int WAIT_LIMIT = 20;

  logic                clk = 1'b0;
  logic                rst;
  logic                in_valid;
  arch_pkg::exec_req_t req;
  logic                out_valid;
  arch_pkg::exec_rsp_t rsp;

  logic [15:0]         lfsr_state = 16'd60722;
  arch_pkg::exec_rsp_t expected[$];
  arch_pkg::exec_rsp_t held_rsp = '0;
  logic                pending_valid = 1'b0;
  int                  sent = 0;
  int                  checked = 0;
  int                  value_errors = 0;
  int                  protocol_errors = 0;

  `include "exec_model.svh"

  exec_stage UUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

  always #5 clk = ~clk;

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic arch_pkg::exec_req_t random_request();
    arch_pkg::exec_req_t r;
    logic [5:0]          code;
    // Only the 35 defined commands
    code = rand_bits(6) % 35;
    r.opc         = cmd_pkg::cmd_t'(code);
    r.eflags      = rand_bits(32);
    r.ecx_is_zero = rand_bits(1);
    r.eip         = rand_bits(32);
    r.instr_len   = rand_bits(4);
    r.opnd0_r     = rand_bits(32);
    r.opnd1_r     = rand_bits(32);
    r.opnd2_r     = rand_bits(32);
    // Equal operands give zero results and LOOP exits
    if (rand_bits(3) == 0) begin
      r.opnd1_r = r.opnd0_r;
      r.opnd2_r = r.opnd1_r;
    end
    if (r.opc >= cmd_pkg::CMD_SHL && r.opc <= cmd_pkg::CMD_ROR) begin
      if (rand_bits(2) == 0) begin
        r.opnd1_r[4:0] = 5'd0;
      end
    end
    return r;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("** Error: %s expected %h, got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic compare_response(input string tag, input arch_pkg::exec_rsp_t exp);
    compare_word({"rsp.eflags", tag}, exp.eflags, rsp.eflags);
    compare_word({"rsp.next_eip", tag}, exp.next_eip, rsp.next_eip);
    compare_word({"rsp.opnd0_w", tag}, exp.opnd0_w, rsp.opnd0_w);
    compare_word({"rsp.opnd1_w", tag}, exp.opnd1_w, rsp.opnd1_w);
  endtask

  // Samples at the falling edge where outputs have settled
  task automatic sample_cycle(output logic got);
    arch_pkg::exec_rsp_t exp;
    @(negedge clk);
    got = (out_valid === 1'b1);
    // Strobe seen one cycle ago must show up now and only then
    assert (out_valid === pending_valid) else begin
      value_errors++;
      $display("** Error: out_valid expected %h, got %h at %0t",
               pending_valid, out_valid, $time);
    end
    if (got) begin
      assert (expected.size() != 0) else begin
        protocol_errors++;
        $display("out_valid was high with no request waiting at %0t", $time);
      end
      if (expected.size() != 0) begin
        exp = expected.pop_front();
        compare_response("", exp);
        checked++;
      end
      held_rsp = rsp;
    end else begin
      // Between strobes the last result stays put
      compare_response(" held", held_rsp);
    end
    pending_valid = in_valid & ~rst;
  endtask

  task automatic wait_response(output logic timed_out);
    logic got;
    int   waited;
    got = 1'b0;
    waited = 0;
    while (!got && waited < WAIT_LIMIT) begin
      sample_cycle(got);
      waited++;
    end
    timed_out = !got;
    if (!got) begin
      $display("No out_valid within %0d cycles for response %0d", WAIT_LIMIT, checked);
    end
  endtask

  initial begin : drive
    int                  cyc;
    logic                v;
    arch_pkg::exec_req_t r;
    rst = 1'b1;
    in_valid = 1'b0;
    req = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    // A few idle cycles right after reset
    repeat (3) @(posedge clk);
    for (cyc = 0; cyc < NUM_REQ * 4 && sent < NUM_REQ; cyc++) begin
      @(posedge clk);
      #1;
      r = random_request();
      // About three strobes in four
      v = (rand_bits(2) != 0);
      req = r;
      in_valid = v;
      if (v) begin
        expected.push_back(expected_response(r));
        sent++;
      end
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  end

  initial begin : check
    int   n;
    logic got;
    logic timed_out;
    timed_out = 1'b0;
    for (n = 0; n < NUM_REQ && !timed_out; n++) begin
      wait_response(timed_out);
    end
    // No stray out_valid once the strobes stop
    if (!timed_out) begin
      repeat (4) begin
        sample_cycle(got);
      end
    end
    $display("Checked %0d of %0d responses, %0d value errors, %0d protocol errors",
             checked, NUM_REQ, value_errors, protocol_errors);
    if (!timed_out && value_errors == 0 && protocol_errors == 0 && checked == NUM_REQ) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+testbench
logic/cmd_pkg.sv
logic/arch_pkg.sv
logic/alu.sv
logic/move_unit.sv
logic/meta_unit.sv
logic/cfu.sv
logic/execute.sv
logic/exec_stage.sv
testbench/tb_exec_stage.sv
